//--- map_pkg.sv
// Address map for 4 targets of 4 KiB each; regions must not overlap, the lowest index wins
`default_nettype none

package map_pkg;

   // Number of target ports behind the demux
   localparam int unsigned NUM_TARGETS = 4;

   // Destination id, wide enough for every target index plus the error id
   typedef logic [2:0] tgt_id_t;

   // Marks a request that matched no region
   localparam tgt_id_t ERR_ID = 3'd4;

   // One address region
   // Hit when (addr & mask) == base
   typedef struct packed {
      logic [31:0] base;
      logic [31:0] mask;
   } region_t;

   // Target k sits at 0x1000_0000 + k * 0x1000
   localparam region_t [NUM_TARGETS-1:0] REGION_MAP = '{
      0: '{base: 32'h1000_0000, mask: 32'hFFFF_F000},
      1: '{base: 32'h1000_1000, mask: 32'hFFFF_F000},
      2: '{base: 32'h1000_2000, mask: 32'hFFFF_F000},
      3: '{base: 32'h1000_3000, mask: 32'hFFFF_F000}
   };

endpackage

`default_nettype wire

//--- bus_pkg.sv
// Request and response formats; single beats only, no byte enables, ids are 4 bits
`default_nettype none

package bus_pkg;

   // Response status
   // DECERR only comes from the local error path
   typedef enum logic {
      OKAY   = 1'b0,
      DECERR = 1'b1
   } rsp_status_e;

   // One request beat from the initiator
   typedef struct packed {
      logic [31:0] addr;
      // High for a write
      logic        we;
      logic [31:0] wdata;
      // Echoed back in the response
      logic [3:0]  id;
   } req_t;

   // One response beat toward the initiator
   typedef struct packed {
      // Zero on writes is fine, the target decides
      logic [31:0] rdata;
      rsp_status_e status;
      logic [3:0]  id;
   } rsp_t;

endpackage

`default_nettype wire

//--- generic_fifo.sv
// Circular FIFO, DATA_DEPTH must be at least 2; data_o is only meaningful while valid_o is high
`default_nettype none

module generic_fifo #(
   parameter int unsigned DATA_DEPTH = 4,
   parameter type         payload_t  = logic [31:0]
) (
   input  logic     clk,
   input  logic     rst_n,
   // Push side
   input  payload_t data_i,
   input  logic     valid_i,
   output logic     grant_o,
   // Pop side
   output payload_t data_o,
   output logic     valid_o,
   input  logic     grant_i
);

   localparam int unsigned PTR_W = $clog2(DATA_DEPTH);

   typedef enum logic [1:0] {
      EMPTY,
      MIDDLE,
      FULL
   } state_e;

   state_e           state_q, state_d;
   logic [PTR_W-1:0] push_ptr_q, push_ptr_d, push_ptr_inc;
   logic [PTR_W-1:0] pop_ptr_q, pop_ptr_d, pop_ptr_inc;
   logic             push, pop;
   payload_t         mem [DATA_DEPTH];

   // Handshake strobes follow straight from the state
   assign grant_o = (state_q != FULL);
   assign valid_o = (state_q != EMPTY);
   assign push    = valid_i & grant_o;
   assign pop     = grant_i & valid_o;

   // Pointers wrap at DATA_DEPTH-1, depth need not be a power of two
   assign push_ptr_inc = (push_ptr_q == PTR_W'(DATA_DEPTH - 1)) ? '0 : push_ptr_q + 1'b1;
   assign pop_ptr_inc  = (pop_ptr_q == PTR_W'(DATA_DEPTH - 1)) ? '0 : pop_ptr_q + 1'b1;

   assign push_ptr_d = push ? push_ptr_inc : push_ptr_q;
   assign pop_ptr_d  = pop ? pop_ptr_inc : pop_ptr_q;

   // Next state
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         EMPTY:
         begin
            // Depth >= 2, so one push never fills it
            if (push)
               state_d = MIDDLE;
         end
         MIDDLE:
         begin
            // Push and pop together keep the fill level
            if (push && !pop && (push_ptr_inc == pop_ptr_q))
               state_d = FULL;
            else if (pop && !push && (pop_ptr_inc == push_ptr_q))
               state_d = EMPTY;
         end
         FULL:
         begin
            if (pop)
               state_d = MIDDLE;
         end
         default:
         begin
            state_d = EMPTY;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= EMPTY;
         push_ptr_q <= '0;
         pop_ptr_q  <= '0;
      end
      else
      begin
         state_q    <= state_d;
         push_ptr_q <= push_ptr_d;
         pop_ptr_q  <= pop_ptr_d;
      end
   end

   // Storage, write enabled by an accepted push
   always_ff @(posedge clk)
   begin
      if (push)
         mem[push_ptr_q] <= data_i;
   end

   // Head of the queue
   assign data_o = mem[pop_ptr_q];

endmodule

`default_nettype wire

//--- addr_decoder.sv
// Request side control; only one unmapped request may wait for its error response at a time
`default_nettype none

module addr_decoder #(
   parameter int unsigned                      NUM_TGT    = map_pkg::NUM_TARGETS,
   parameter map_pkg::region_t [NUM_TGT-1:0] REGION_MAP = map_pkg::REGION_MAP
) (
   input  logic                        clk,
   input  logic                        rst_n,
   // Initiator request
   input  logic                        req_valid_i,
   input  bus_pkg::req_t               req_i,
   output logic                        req_grant_o,
   // Target requests
   output logic [NUM_TGT-1:0]          tgt_req_valid_o,
   output bus_pkg::req_t [NUM_TGT-1:0] tgt_req_o,
   input  logic [NUM_TGT-1:0]          tgt_req_grant_i,
   // Destination FIFO push
   output logic                        dst_push_o,
   output map_pkg::tgt_id_t            dst_id_o,
   input  logic                        dst_grant_i,
   // Pending error handoff to the router
   output logic [3:0]                  err_id_o,
   input  logic                        err_done_i
);

   logic [NUM_TGT-1:0] hit;
   logic               mapped;
   map_pkg::tgt_id_t   sel;
   logic               tgt_grant;
   logic               err_accept;
   logic               err_pend_q;
   logic [3:0]         err_id_q;

   // Region match per target
   always_comb
   begin
      for (int k = 0; k < NUM_TGT; k++)
         hit[k] = ((req_i.addr & REGION_MAP[k].mask) == REGION_MAP[k].base);
   end

   assign mapped = |hit;

   // Lowest matching index
   always_comb
   begin
      sel = '0;
      for (int k = NUM_TGT - 1; k >= 0; k--)
      begin
         if (hit[k])
            sel = map_pkg::tgt_id_t'(k);
      end
   end

   // One-hot target valid, held back while the destination FIFO is full
   always_comb
   begin
      tgt_req_valid_o = '0;
      tgt_grant       = 1'b0;
      for (int k = 0; k < NUM_TGT; k++)
      begin
         if (mapped && (sel == map_pkg::tgt_id_t'(k)))
         begin
            tgt_req_valid_o[k] = req_valid_i & dst_grant_i;
            tgt_grant          = tgt_req_grant_i[k];
         end
      end
   end

   // Request fans out to all targets, valid picks the one
   always_comb
   begin
      for (int k = 0; k < NUM_TGT; k++)
         tgt_req_o[k] = req_i;
   end

   // Unmapped requests wait while an earlier error is still pending
   assign req_grant_o = req_valid_i & dst_grant_i & (mapped ? tgt_grant : ~err_pend_q);

   // Every accepted request leaves its destination behind
   assign dst_push_o = req_grant_o;
   assign dst_id_o   = mapped ? sel : map_pkg::ERR_ID;

   assign err_accept = req_grant_o & ~mapped;

   // Pending error flag, a new accept wins over the clear
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         err_pend_q <= 1'b0;
      else if (err_accept)
         err_pend_q <= 1'b1;
      else if (err_done_i)
         err_pend_q <= 1'b0;
   end

   // Id of the unmapped request
   always_ff @(posedge clk)
   begin
      if (err_accept)
         err_id_q <= req_i.id;
   end

   assign err_id_o = err_id_q;

endmodule

`default_nettype wire

//--- rsp_router.sv
// Purely combinational; a target response is taken only while its id heads the destination FIFO
`default_nettype none

module rsp_router #(
   parameter int unsigned NUM_TGT = map_pkg::NUM_TARGETS
) (
   // Destination FIFO head
   input  logic                        dst_valid_i,
   input  map_pkg::tgt_id_t            dst_id_i,
   output logic                        dst_pop_o,
   // Pending error from the decoder
   input  logic [3:0]                  err_id_i,
   output logic                        err_done_o,
   // Target responses
   input  logic [NUM_TGT-1:0]          tgt_rsp_valid_i,
   input  bus_pkg::rsp_t [NUM_TGT-1:0] tgt_rsp_i,
   output logic [NUM_TGT-1:0]          tgt_rsp_grant_o,
   // Response FIFO push
   output logic                        rsp_push_o,
   output bus_pkg::rsp_t               rsp_data_o,
   input  logic                        rsp_grant_i
);

   logic is_err;
   logic tgt_valid;

   // Head names the local error path
   assign is_err = dst_valid_i & (dst_id_i == map_pkg::ERR_ID);

   // Mux the head target, default is the DECERR beat
   always_comb
   begin
      tgt_valid         = 1'b0;
      tgt_rsp_grant_o   = '0;
      rsp_data_o.rdata  = '0;
      rsp_data_o.status = bus_pkg::DECERR;
      rsp_data_o.id     = err_id_i;
      for (int k = 0; k < NUM_TGT; k++)
      begin
         if (dst_valid_i && (dst_id_i == map_pkg::tgt_id_t'(k)))
         begin
            tgt_valid          = tgt_rsp_valid_i[k];
            tgt_rsp_grant_o[k] = rsp_grant_i;
            rsp_data_o         = tgt_rsp_i[k];
         end
      end
   end

   assign rsp_push_o = is_err | tgt_valid;

   // Pop and error release happen in the transfer cycle
   assign dst_pop_o  = rsp_push_o & rsp_grant_i;
   assign err_done_o = is_err & rsp_grant_i;

endmodule

`default_nettype wire

//--- demux_top.sv
// Single initiator demux; responses return in request order, OUTSTANDING and RSP_DEPTH >= 2
`default_nettype none

module demux_top #(
   parameter int unsigned OUTSTANDING = 4,
   parameter int unsigned RSP_DEPTH   = 2,
   parameter int unsigned NUM_TGT     = map_pkg::NUM_TARGETS
) (
   input  logic                        clk,
   input  logic                        rst_n,
   // Initiator side
   input  logic                        req_valid_i,
   input  bus_pkg::req_t               req_i,
   output logic                        req_grant_o,
   output logic                        rsp_valid_o,
   output bus_pkg::rsp_t               rsp_o,
   input  logic                        rsp_grant_i,
   // Target side
   output logic [NUM_TGT-1:0]          tgt_req_valid_o,
   output bus_pkg::req_t [NUM_TGT-1:0] tgt_req_o,
   input  logic [NUM_TGT-1:0]          tgt_req_grant_i,
   input  logic [NUM_TGT-1:0]          tgt_rsp_valid_i,
   input  bus_pkg::rsp_t [NUM_TGT-1:0] tgt_rsp_i,
   output logic [NUM_TGT-1:0]          tgt_rsp_grant_o
);

   // Destination FIFO links
   logic             dst_push, dst_grant, dst_valid, dst_pop;
   map_pkg::tgt_id_t dst_id, dst_head;
   // Error handoff
   logic [3:0]       err_id;
   logic             err_done;
   // Response FIFO push side
   logic             rsp_push, rsp_fifo_grant;
   bus_pkg::rsp_t    rsp_data;

   addr_decoder #(
      .NUM_TGT    (NUM_TGT),
      .REGION_MAP (map_pkg::REGION_MAP)
   ) u_addr_decoder (
      .clk             (clk),
      .rst_n           (rst_n),
      .req_valid_i     (req_valid_i),
      .req_i           (req_i),
      .req_grant_o     (req_grant_o),
      .tgt_req_valid_o (tgt_req_valid_o),
      .tgt_req_o       (tgt_req_o),
      .tgt_req_grant_i (tgt_req_grant_i),
      .dst_push_o      (dst_push),
      .dst_id_o        (dst_id),
      .dst_grant_i     (dst_grant),
      .err_id_o        (err_id),
      .err_done_i      (err_done)
   );

   // Order of outstanding requests
   generic_fifo #(
      .DATA_DEPTH (OUTSTANDING),
      .payload_t  (map_pkg::tgt_id_t)
   ) u_dst_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_i  (dst_id),
      .valid_i (dst_push),
      .grant_o (dst_grant),
      .data_o  (dst_head),
      .valid_o (dst_valid),
      .grant_i (dst_pop)
   );

   rsp_router #(
      .NUM_TGT (NUM_TGT)
   ) u_rsp_router (
      .dst_valid_i     (dst_valid),
      .dst_id_i        (dst_head),
      .dst_pop_o       (dst_pop),
      .err_id_i        (err_id),
      .err_done_o      (err_done),
      .tgt_rsp_valid_i (tgt_rsp_valid_i),
      .tgt_rsp_i       (tgt_rsp_i),
      .tgt_rsp_grant_o (tgt_rsp_grant_o),
      .rsp_push_o      (rsp_push),
      .rsp_data_o      (rsp_data),
      .rsp_grant_i     (rsp_fifo_grant)
   );

   // Response buffer toward the initiator
   generic_fifo #(
      .DATA_DEPTH (RSP_DEPTH),
      .payload_t  (bus_pkg::rsp_t)
   ) u_rsp_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_i  (rsp_data),
      .valid_i (rsp_push),
      .grant_o (rsp_fifo_grant),
      .data_o  (rsp_o),
      .valid_o (rsp_valid_o),
      .grant_i (rsp_grant_i)
   );

endmodule

`default_nettype wire

//--- demux_sva.sv
// Protocol checks bound into demux_top; every property is off while rst_n is low
`default_nettype none

module demux_sva #(
   parameter int unsigned NUM_TGT     = 4,
   parameter int unsigned OUTSTANDING = 4
) (
   input logic               clk,
   input logic               rst_n,
   input logic [NUM_TGT-1:0] tgt_req_valid_i,
   input logic               req_grant_i,
   input logic               rsp_valid_i,
   input logic               rsp_grant_i,
   input logic               dst_pop_i
);

   // Failures seen so far
   int unsigned fail_cnt = 0;
   // Requests in flight, rebuilt from grants and destination pops
   int unsigned occ_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         occ_q <= 0;
      else if (req_grant_i && !dst_pop_i)
         occ_q <= occ_q + 1;
      else if (dst_pop_i && !req_grant_i)
         occ_q <= occ_q - 1;
   end

   // Never two targets at once
   assert property (@(posedge clk) disable iff (!rst_n) $onehot0(tgt_req_valid_i))
   else
   begin
      $error("more than one target request valid");
      fail_cnt++;
   end

   // Response held until the initiator takes it
   assert property (@(posedge clk) disable iff (!rst_n)
                    rsp_valid_i && !rsp_grant_i |=> rsp_valid_i)
   else
   begin
      $error("response valid dropped before grant");
      fail_cnt++;
   end

   // Full destination FIFO blocks new requests
   assert property (@(posedge clk) disable iff (!rst_n)
                    (occ_q == OUTSTANDING) |-> !req_grant_i)
   else
   begin
      $error("request granted with the destination FIFO full");
      fail_cnt++;
   end

endmodule

bind demux_top demux_sva #(
   .NUM_TGT     (NUM_TGT),
   .OUTSTANDING (OUTSTANDING)
) u_demux_sva (
   .clk             (clk),
   .rst_n           (rst_n),
   .tgt_req_valid_i (tgt_req_valid_o),
   .req_grant_i     (req_grant_o),
   .rsp_valid_i     (rsp_valid_o),
   .rsp_grant_i     (rsp_grant_i),
   .dst_pop_i       (dst_pop)
);

`default_nettype wire

//--- tb_demux.sv
// Directed testbench for demux_top; targets grant at once and the run stops at a fixed cycle limit
`default_nettype none

module tb_demux;

   localparam int NT          = map_pkg::NUM_TARGETS;
   localparam int OUTSTANDING = 4;
   // Generous bound over all directed tests
   localparam int TIMEOUT     = 2000;

   logic                        clk = 1'b0;
   logic                        rst_n = 1'b0;
   logic                        req_valid = 1'b0;
   bus_pkg::req_t               req = '0;
   logic                        req_grant;
   logic                        rsp_valid;
   bus_pkg::rsp_t               rsp;
   logic                        rsp_grant = 1'b1;
   logic [NT-1:0]               tgt_req_valid;
   bus_pkg::req_t [NT-1:0]      tgt_req;
   logic [NT-1:0]               tgt_req_grant = '1;
   wire [NT-1:0]                tgt_rsp_valid;
   wire bus_pkg::rsp_t [NT-1:0] tgt_rsp;
   logic [NT-1:0]               tgt_rsp_grant;

   integer        seed = 32'h88f447d0;
   int            errors = 0;
   int            rsp_cnt = 0;
   int            tgt_done = 0;
   int            cycle = 0;
   int            lat [NT];
   logic          hold_rsp = 1'b0;
   string         test_name = "init";
   // Expected responses in issue order
   bus_pkg::rsp_t exp_q [$];

   demux_top #(
      .OUTSTANDING (OUTSTANDING),
      .RSP_DEPTH   (2),
      .NUM_TGT     (NT)
   ) u_demux_top (
      .clk             (clk),
      .rst_n           (rst_n),
      .req_valid_i     (req_valid),
      .req_i           (req),
      .req_grant_o     (req_grant),
      .rsp_valid_o     (rsp_valid),
      .rsp_o           (rsp),
      .rsp_grant_i     (rsp_grant),
      .tgt_req_valid_o (tgt_req_valid),
      .tgt_req_o       (tgt_req),
      .tgt_req_grant_i (tgt_req_grant),
      .tgt_rsp_valid_i (tgt_rsp_valid),
      .tgt_rsp_i       (tgt_rsp),
      .tgt_rsp_grant_o (tgt_rsp_grant)
   );

   always #2 clk = ~clk;

   // Region index of an address, -1 when unmapped
   function automatic int region_of(input logic [31:0] addr);
      int k;
      k = -1;
      for (int j = 0; j < NT; j++)
      begin
         if ((addr & 32'hFFFF_F000) == 32'h1000_0000 + 32'(j) * 32'h1000)
            k = j;
      end
      return k;
   endfunction

   // Answer of target k to one request
   function automatic bus_pkg::rsp_t model_rsp(input bus_pkg::req_t r, input int k);
      bus_pkg::rsp_t a;
      a.rdata  = r.we ? r.wdata : (r.addr ^ 32'hA5A5_0000) + 32'(k);
      a.status = bus_pkg::OKAY;
      a.id     = r.id;
      return a;
   endfunction

   // What the initiator should see, DECERR for a hole in the map
   function automatic bus_pkg::rsp_t expected_rsp(input bus_pkg::req_t r);
      bus_pkg::rsp_t e;
      int            k;
      k = region_of(r.addr);
      if (k < 0)
      begin
         e.rdata  = '0;
         e.status = bus_pkg::DECERR;
         e.id     = r.id;
      end
      else
         e = model_rsp(r, k);
      return e;
   endfunction

   // Random offset inside a region, tgt < 0 picks an unmapped address
   function automatic bus_pkg::req_t mk_req(input int tgt, input logic we, input logic [3:0] id);
      bus_pkg::req_t r;
      logic [31:0]   base;
      base    = (tgt < 0) ? 32'h2000_0000 : 32'h1000_0000 + 32'(tgt) * 32'h1000;
      r.addr  = base + (32'($random(seed)) & 32'h0000_0FFC);
      r.we    = we;
      r.wdata = 32'($random(seed));
      r.id    = id;
      return r;
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_req(input string name, input bus_pkg::req_t exp,
                            input bus_pkg::req_t act);
      if (act !== exp)
      begin
         $display("** Error %s: expected addr %h we %b wdata %h id %h", name,
                  exp.addr, exp.we, exp.wdata, exp.id);
         $display("   actual addr %h we %b wdata %h id %h", act.addr, act.we, act.wdata, act.id);
         errors++;
      end
   endtask

   task automatic check_rsp(input string name, input bus_pkg::rsp_t exp,
                            input bus_pkg::rsp_t act);
      if (act !== exp)
      begin
         $display("** Error %s: expected rdata %h %s id %h, actual rdata %h %s id %h", name,
                  exp.rdata, exp.status.name(), exp.id, act.rdata, act.status.name(), act.id);
         errors++;
      end
   endtask

   // Target models, one per port
   for (genvar k = 0; k < NT; k++)
   begin : g_tgt
      bus_pkg::rsp_t rsp_q [$];
      int            due_q [$];
      int            now_c = 0;
      logic          valid_r = 1'b0;
      bus_pkg::rsp_t rsp_r = '0;

      assign tgt_rsp_valid[k] = valid_r;
      assign tgt_rsp[k]       = rsp_r;

      always @(posedge clk)
      begin
         now_c = now_c + 1;
         if (tgt_rsp_valid[k] && tgt_rsp_grant[k])
         begin
            void'(rsp_q.pop_front());
            void'(due_q.pop_front());
            tgt_done++;
         end
         // Routing of each accepted request
         if (req_valid && req_grant)
         begin
            check_bit({test_name, " tgt valid"}, region_of(req.addr) == k, tgt_req_valid[k]);
            if (tgt_req_valid[k])
               check_req({test_name, " tgt req"}, req, tgt_req[k]);
         end
         if (tgt_req_valid[k] && tgt_req_grant[k])
         begin
            rsp_q.push_back(model_rsp(tgt_req[k], k));
            due_q.push_back(now_c + lat[k]);
         end
         #1;
         valid_r = 1'b0;
         rsp_r   = '0;
         if (!hold_rsp && rsp_q.size() > 0)
         begin
            if (now_c >= due_q[0])
            begin
               valid_r = 1'b1;
               rsp_r   = rsp_q[0];
            end
         end
      end
   end

   // Scoreboard on the initiator response port
   always @(posedge clk)
   begin
      if (rst_n && rsp_valid && rsp_grant)
      begin
         rsp_cnt++;
         if (exp_q.size() == 0)
         begin
            $display("%s: response id %h came back with no request outstanding",
                     test_name, rsp.id);
            errors++;
         end
         else
            check_rsp(test_name, exp_q.pop_front(), rsp);
      end
   end

   always @(posedge clk)
   begin
      cycle = cycle + 1;
      if (cycle >= TIMEOUT)
      begin
         $display("Timeout after %0d cycles, test %s never completed", cycle, test_name);
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic set_lat(input int l0, input int l1, input int l2, input int l3);
      lat[0] = l0;
      lat[1] = l1;
      lat[2] = l2;
      lat[3] = l3;
   endtask

   // Waits for the grant of the request on req, then records its answer
   task automatic wait_grant();
      @(posedge clk);
      while (!req_grant)
         @(posedge clk);
      exp_q.push_back(expected_rsp(req));
      #1 req_valid = 1'b0;
   endtask

   task automatic send(input bus_pkg::req_t r);
      req       = r;
      req_valid = 1'b1;
      wait_grant();
   endtask

   // Until every expected response has come back
   task automatic drain();
      do
         @(posedge clk);
      while (exp_q.size() != 0);
      #1;
   endtask

   task automatic check_idle();
      check_bit({test_name, " tgt_req_valid"}, 1'b0, |tgt_req_valid);
      check_bit({test_name, " tgt_rsp_grant"}, 1'b0, |tgt_rsp_grant);
      check_bit({test_name, " rsp_valid"}, 1'b0, rsp_valid);
      check_bit({test_name, " req_grant"}, 1'b0, req_grant);
   endtask

   task automatic test_reset();
      test_name = "reset";
      rst_n     = 1'b0;
      repeat (10)
      begin
         @(posedge clk);
         check_idle();
      end
      #1 rst_n = 1'b1;
      @(posedge clk);
      check_idle();
      #1;
   endtask

   task automatic test_routing();
      test_name = "routing";
      set_lat(1, 2, 3, 4);
      for (int i = 0; i < NT; i++)
         send(mk_req(i, (i % 2 == 1), 4'(i + 8)));
      drain();
   endtask

   // Slow target first, later answers must wait behind it
   task automatic test_order();
      test_name = "order";
      set_lat(1, 1, 3, 12);
      send(mk_req(3, 1'b0, 4'h1));
      send(mk_req(0, 1'b0, 4'h2));
      send(mk_req(2, 1'b1, 4'h3));
      drain();
   endtask

   // Two holes in the map, the second waits for the first error slot
   task automatic test_unmapped();
      test_name = "unmapped";
      set_lat(2, 2, 2, 2);
      send(mk_req(1, 1'b0, 4'h3));
      send(mk_req(-1, 1'b0, 4'h4));
      send(mk_req(2, 1'b1, 4'h5));
      send(mk_req(-1, 1'b1, 4'h6));
      send(mk_req(0, 1'b0, 4'h7));
      drain();
   endtask

   task automatic test_outstanding();
      int done_base;
      test_name = "outstanding";
      set_lat(0, 0, 0, 0);
      hold_rsp = 1'b1;
      for (int i = 0; i < OUTSTANDING; i++)
         send(mk_req(i % NT, 1'b0, 4'(i)));
      // One more than the destination FIFO holds
      req       = mk_req(1, 1'b0, 4'h9);
      req_valid = 1'b1;
      repeat (10)
      begin
         @(posedge clk);
         check_bit({test_name, " req_grant"}, 1'b0, req_grant);
      end
      done_base = tgt_done;
      hold_rsp  = 1'b0;
      wait_grant();
      check_bit({test_name, " target answer first"}, 1'b1, tgt_done > done_base);
      drain();
   endtask

   task automatic test_backpressure();
      test_name = "backpressure";
      set_lat(2, 5, 1, 3);
      rsp_grant = 1'b0;
      fork
         begin
            for (int i = 0; i < 8; i++)
               send(mk_req((i == 4) ? -1 : i % NT, (i % 2 == 1), 4'(i)));
         end
         begin
            repeat (20)
               @(posedge clk);
            // Both FIFOs are full by now and the next request is stuck
            check_bit({test_name, " rsp_valid held"}, 1'b1, rsp_valid);
            check_bit({test_name, " tgt_rsp_grant"}, 1'b0, |tgt_rsp_grant);
            check_bit({test_name, " req_grant"}, 1'b0, req_grant);
            #1 rsp_grant = 1'b1;
         end
      join
      drain();
   endtask

   initial
   begin
      set_lat(1, 1, 1, 1);
      test_reset();
      test_routing();
      test_order();
      test_unmapped();
      test_outstanding();
      test_backpressure();
      repeat (4)
         @(posedge clk);
      $display("Errors: %0d, assertion failures: %0d, responses: %0d", errors,
               u_demux_top.u_demux_sva.fail_cnt, rsp_cnt);
      if (errors == 0 && u_demux_top.u_demux_sva.fail_cnt == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
map_pkg.sv
bus_pkg.sv
generic_fifo.sv
addr_decoder.sv
rsp_router.sv
demux_top.sv
demux_sva.sv
tb_demux.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_demux
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
